// File: design/fir_coef_pkg.sv
// FIR coefficient table
// 32-tap symmetric low-pass response, Q4.16 format.
// Entry k weights the sample that is k steps old

`default_nettype none

`include "fir_config.svh"

package fir_coef_pkg;

  import fir_types_pkg::*;

  localparam coef_t fir_coefs [`FIR_TAPS] = '{
    20'hFFF9E,  // -1.50e-3
    20'hFFF86,  // -1.86e-3
    20'hFFFA7,  // -1.36e-3
    20'h0003B,
    20'h0014B,
    20'h0024A,
    20'h00222,
    20'hFFFE4,  // Sidelobe dip starts
    20'hFFBC5,
    20'hFF7CA,
    20'hFF74E,  // -3.40e-2
    20'hFFD74,
    20'h00B1A,
    20'h01DAC,
    20'h02F9E,
    20'h03AA9,  // Centre pair, 2.29e-1
    20'h03AA9,
    20'h02F9E,
    20'h01DAC,
    20'h00B1A,
    20'hFFD74,
    20'hFF74E,
    20'hFF7CA,
    20'hFFBC5,
    20'hFFFE4,
    20'h00222,
    20'h0024A,
    20'h0014B,
    20'h0003B,
    20'hFFFA7,
    20'hFFF86,
    20'hFFF9E   // Mirror of entry 0
  };

endpackage

`default_nettype wire

// File: design/fir_config.svh
// FIR filter configuration
// Tap count, slice split, datapath widths and coefficient scaling
// shared by the packages and the RTL

`ifndef FIR_CONFIG_SVH
`define FIR_CONFIG_SVH

//////////////////////////////////////////////////
// Filter geometry
`define FIR_TAPS            32
`define FIR_TAPS_PER_SLICE  4
`define FIR_SLICES          (`FIR_TAPS / `FIR_TAPS_PER_SLICE)

//////////////////////////////////////////////////
// Datapath widths
`define FIR_SAMPLE_W        16
`define FIR_COEF_W          20
`define FIR_FRAC_BITS       16   // Coefficient fraction bits
`define FIR_ACC_W           42   // Holds 32 products of 36 bits

`endif

// File: design/fir_filter.sv
// FIR filter top level
// 32-tap symmetric low-pass filter on signed 16-bit samples.
// Input stage, eight four-tap slices and the summing output stage,
// three cycles from accepted sample to fir_valid

`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_filter
  import fir_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,
  input  sample_t data,
  output logic    fir_valid,
  output sample_t fir_d
);

  logic     shift_en;
  logic     window_valid;
  sample_t  sample_chain [`FIR_SLICES + 1];  // Entry 0 is the newest sample
  partial_t partial_sums [`FIR_SLICES];

  fir_sample_gate gate_inst (
    .clk          (clk),
    .rst          (rst),
    .data_valid   (data_valid),
    .data         (data),
    .shift_en     (shift_en),
    .shift_sample (sample_chain[0]),
    .window_valid (window_valid)
  );

  //////////////////////////////////////////////////
  // Tap slices, newest first
  for (genvar i = 0; i < `FIR_SLICES; i++) begin : g_slice
    fir_tap_slice #(
      .SLICE_INDEX (i)
    ) slice_inst (
      .clk         (clk),
      .rst         (rst),
      .shift_en    (shift_en),
      .sample_in   (sample_chain[i]),
      .sample_tail (sample_chain[i+1]),  // Last entry leaves the window
      .partial     (partial_sums[i])
    );
  end

  fir_sum_round sum_inst (
    .clk          (clk),
    .rst          (rst),
    .window_valid (window_valid),
    .partials     (partial_sums),
    .fir_valid    (fir_valid),
    .fir_d        (fir_d)
  );

endmodule

`default_nettype wire

// File: design/fir_sample_gate.sv
// FIR input stage
// Registers each accepted sample with a shift strobe for the tap chain.
// Tracks how many samples of the current run have been taken and flags
// the samples for which the 32-tap window is complete

`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_sample_gate
  import fir_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    data_valid,
  input  sample_t data,
  output logic    shift_en,
  output sample_t shift_sample,
  output logic    window_valid
);

  localparam int CNT_W = $clog2(`FIR_TAPS + 1);

  warm_state_t      state;
  warm_state_t      state_next;
  logic [CNT_W-1:0] fill_cnt;        // Samples taken in this run, saturates
  logic [CNT_W-1:0] fill_cnt_next;

  //////////////////////////////////////////////////
  // Warm-up FSM
  always_comb begin
    state_next    = state;
    fill_cnt_next = fill_cnt;
    if (!data_valid) begin           // A low cycle breaks the run
      state_next    = WARM_IDLE;
      fill_cnt_next = '0;
    end else begin
      case (state)
        WARM_IDLE, WARM_FILL: begin
          fill_cnt_next = fill_cnt + 1'b1;
          if (fill_cnt_next == CNT_W'(`FIR_TAPS)) begin
            state_next = WARM_RUN;
          end else begin
            state_next = WARM_FILL;
          end
        end
        WARM_RUN: state_next = WARM_RUN;  // Count holds at the window length
        default:  state_next = WARM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= WARM_IDLE;
      fill_cnt     <= '0;
      shift_en     <= 1'b0;
      window_valid <= 1'b0;
    end else begin
      state        <= state_next;
      fill_cnt     <= fill_cnt_next;
      shift_en     <= data_valid;
      window_valid <= (state_next == WARM_RUN);  // Includes the 32nd sample
    end
  end

  always_ff @(posedge clk) begin
    if (data_valid) begin
      shift_sample <= data;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  a_fill_bound: assert property (@(posedge clk) disable iff (rst)
    fill_cnt <= CNT_W'(`FIR_TAPS));

  // A complete window is only ever reported together with a tap shift
  a_window_shift: assert property (@(posedge clk) disable iff (rst)
    window_valid |-> shift_en);

endmodule

`default_nettype wire

// File: design/fir_sum_round.sv
// FIR output stage
// Adds the slice partial sums into the full accumulator, rounds the
// result to a 16-bit sample and presents it with a one-cycle fir_valid

`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_sum_round
  import fir_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     window_valid,
  input  partial_t partials [`FIR_SLICES],
  output logic     fir_valid,
  output sample_t  fir_d
);

  localparam int KEEP_LO = `FIR_FRAC_BITS;
  localparam int KEEP_HI = `FIR_FRAC_BITS + `FIR_SAMPLE_W - 2;

  // Bit 0 lines up with the tap shift, bit 1 with the partial sums
  logic [1:0] win_pipe;
  acc_t       acc_sum;
  sample_t    rounded;

  //////////////////////////////////////////////////
  // Sum of slices
  always_comb begin
    acc_sum = '0;
    for (int s = 0; s < `FIR_SLICES; s++) begin
      acc_sum = acc_sum + acc_t'(partials[s]);  // Sign extended
    end
  end

  //////////////////////////////////////////////////
  // Rounding
  // Sign bit on top, then the integer part of the sum. Negative
  // results get one added to the truncated word
  always_comb begin
    rounded = {acc_sum[`FIR_ACC_W-1], acc_sum[KEEP_HI:KEEP_LO]};
    if (acc_sum[`FIR_ACC_W-1]) begin
      rounded = rounded + sample_t'(1);
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      win_pipe  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else begin
      win_pipe  <= {win_pipe[0], window_valid};
      fir_valid <= win_pipe[1];
      if (win_pipe[1]) begin
        fir_d <= rounded;  // Holds the last result between valid cycles
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks
  // The gate, slices and this stage together need three edges before
  // any result can appear after reset
  a_no_early_valid: assert property (@(posedge clk)
    $fell(rst) |-> !fir_valid ##1 !fir_valid ##1 !fir_valid);

endmodule

`default_nettype wire

// File: design/fir_tap_slice.sv
// FIR tap slice
// Four taps of the delay line with their coefficients. Shifts on the
// strobe from the input stage, passes its oldest sample on, and
// registers the sum of its four products every cycle

`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module fir_tap_slice
  import fir_types_pkg::*, fir_coef_pkg::*;
#(
  parameter int SLICE_INDEX = 0
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     shift_en,
  input  sample_t  sample_in,
  output sample_t  sample_tail,
  output partial_t partial
);

  localparam int TPS       = `FIR_TAPS_PER_SLICE;
  localparam int COEF_BASE = SLICE_INDEX * TPS;   // Age of this slice's newest tap

  sample_t  taps [TPS];
  partial_t prod_sum;

  //////////////////////////////////////////////////
  // Delay line
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int j = 0; j < TPS; j++) begin
        taps[j] <= '0;
      end
    end else if (shift_en) begin
      taps[0] <= sample_in;
      for (int j = 1; j < TPS; j++) begin
        taps[j] <= taps[j-1];
      end
    end
  end

  assign sample_tail = taps[TPS-1];  // Feeds the next older slice

  //////////////////////////////////////////////////
  // Multiply and partial sum
  always_comb begin
    prod_sum = '0;
    for (int j = 0; j < TPS; j++) begin
      prod_sum = prod_sum + taps[j] * fir_coefs[COEF_BASE + j];
    end
  end

  // Pipeline register, runs every cycle
  always_ff @(posedge clk) begin
    partial <= prod_sum;
  end

endmodule

`default_nettype wire

// File: design/fir_types_pkg.sv
// FIR datapath types
// Sample, coefficient, slice partial-sum and accumulator words,
// plus the warm-up states of the input stage

`default_nettype none

`include "fir_config.svh"

package fir_types_pkg;

  //////////////////////////////////////////////////
  // Datapath words
  typedef logic signed [`FIR_SAMPLE_W-1:0] sample_t;   // Input and output sample
  typedef logic signed [`FIR_COEF_W-1:0]   coef_t;     // Q4.16 coefficient

  // Sum of one slice's four products, three bits narrower than the full sum
  typedef logic signed [`FIR_ACC_W-4:0]    partial_t;

  typedef logic signed [`FIR_ACC_W-1:0]    acc_t;      // Sum over all taps

  //////////////////////////////////////////////////
  // Warm-up control of the input stage
  typedef enum logic [1:0] {
    WARM_IDLE = 2'd0,  // No run in progress
    WARM_FILL = 2'd1,  // Run started, window not yet full
    WARM_RUN  = 2'd2   // Window holds a full run of samples
  } warm_state_t;

endpackage

`default_nettype wire

// File: fir_filter.f
+incdir+design
design/fir_types_pkg.sv
design/fir_coef_pkg.sv
design/fir_sample_gate.sv
design/fir_tap_slice.sv
design/fir_sum_round.sv
design/fir_filter.sv
tests/tb_clock.sv
tests/tb_fir_filter.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FIR filter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fir_filter \
  -f fir_filter.f -Mdir obj_dir -o tb_fir_filter > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_fir_filter > sim.log 2>&1

grep -qx "Test OK" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// File: tests/tb_clock.sv
// Testbench clock and reset
// Free-running clock and an active-high reset held for a set number of cycles

`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // Released away from the active edge
  end

endmodule

`default_nettype wire

// File: tests/tb_fir_filter.sv
// FIR filter testbench
// Drives sample runs into the filter, predicts each result with a
// delay-line model and checks values, pulse counts and latency

`timescale 1ns/10ps
`default_nettype none

`include "fir_config.svh"

module tb_fir_filter
  import fir_types_pkg::*, fir_coef_pkg::*;
;

  localparam int      PERIOD         = 40;
  localparam int      RESET_CYCLES   = 16;
  localparam int      LATENCY        = 3;
  localparam int      DRAIN_CYCLES   = 8;
  localparam int      IDLE_CYCLES    = 20;
  localparam int      IMPULSE_CYCLES = 2 * `FIR_TAPS - 1;
  localparam int      STREAM_CYCLES  = 400;
  localparam int      FIRST_RUN      = 40;
  localparam int      SECOND_RUN     = 50;
  localparam int      TOGGLE_CYCLES  = 600;
  localparam int      LATENCY_CYCLES = `FIR_TAPS + 2 * LATENCY;
  localparam int      TEST_CYCLES    = IDLE_CYCLES + IMPULSE_CYCLES + STREAM_CYCLES +
                                       FIRST_RUN + 1 + SECOND_RUN + TOGGLE_CYCLES +
                                       LATENCY_CYCLES + 6 * DRAIN_CYCLES;
  localparam int      TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;
  localparam sample_t IMPULSE        = 16'sd16384;

  logic    clk;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;

  integer  seed;
  int      error_count = 0;
  int      check_count = 0;
  int      test_count  = 0;
  int      test_errors_base;
  int      edge_count  = 0;            // Rising edges so far
  int      run_count;                  // Model fill count, saturates at the tap count
  int      pulses_seen;
  int      pulses_expected;
  logic    valid_prev  = 1'b0;
  logic    capture_on  = 1'b0;
  sample_t model_line [`FIR_TAPS];     // Entry k is the sample k steps old
  sample_t expected_q [$];
  int      rise_q [$];                 // Accepting edge of each run's 32nd sample
  sample_t capture_q [$];

  tb_clock #(
    .PERIOD       (PERIOD),
    .RESET_CYCLES (RESET_CYCLES)
  ) clock_inst (
    .clk (clk),
    .rst (rst)
  );

  fir_filter fir_filter_inst (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  always @(posedge clk) edge_count <= edge_count + 1;

  //////////////////////////////////////////////////
  // Reference model

  // Sign on top, bits 30..16 below, plus one for a negative sum
  function automatic sample_t round_to_sample(input acc_t sum);
    sample_t word;
    word = {sum[`FIR_ACC_W-1], sum[`FIR_FRAC_BITS+`FIR_SAMPLE_W-2:`FIR_FRAC_BITS]};
    if (sum[`FIR_ACC_W-1]) begin
      word = word + sample_t'(1);
    end
    return word;
  endfunction

  function automatic sample_t reference_fir();
    acc_t sum;
    sum = '0;
    for (int k = 0; k < `FIR_TAPS; k++) begin
      sum = sum + acc_t'(model_line[k]) * acc_t'(fir_coefs[k]);
    end
    return round_to_sample(sum);
  endfunction

  task automatic model_cycle(input logic valid, input sample_t sample);
    if (!valid) begin
      run_count = 0;                   // Run broken
    end else begin
      for (int k = `FIR_TAPS - 1; k > 0; k--) begin
        model_line[k] = model_line[k-1];
      end
      model_line[0] = sample;
      if (run_count < `FIR_TAPS) begin
        run_count++;
        if (run_count == `FIR_TAPS) begin
          rise_q.push_back(edge_count + 1);  // Edge that takes this sample
        end
      end
      if (run_count == `FIR_TAPS) begin
        expected_q.push_back(reference_fir());
        pulses_expected++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus and checking helpers

  task automatic compare_value(input string name, input longint actual,
                               input longint expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
    end
  endtask

  task automatic drive_cycle(input logic valid, input sample_t sample);
    @(negedge clk);
    data_valid = valid;
    data       = sample;
    model_cycle(valid, sample);
  endtask

  task automatic begin_test();
    pulses_seen      = 0;
    pulses_expected  = 0;
    test_errors_base = error_count;
  endtask

  task automatic flush_pipeline();
    repeat (DRAIN_CYCLES) drive_cycle(1'b0, '0);
  endtask

  task automatic end_test(input string name);
    compare_value("fir_valid pulses", pulses_seen, pulses_expected);
    test_count++;
    if (error_count == test_errors_base) begin
      $display("test %0d %s: %0d outputs, clean", test_count, name, pulses_seen);
    end else begin
      $display("test %0d %s: %0d outputs, %0d errors", test_count, name, pulses_seen,
               error_count - test_errors_base);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests

  task automatic idle_after_reset();
    begin_test();
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      drive_cycle(1'b0, '0);
      compare_value("fir_valid", fir_valid, 0);
      compare_value("fir_d", fir_d, 0);
    end
    end_test("idle after reset");
  endtask

  task automatic impulse_response();
    begin_test();
    capture_q.delete();
    capture_on = 1'b1;
    repeat (`FIR_TAPS - 1) drive_cycle(1'b1, '0);
    drive_cycle(1'b1, IMPULSE);
    repeat (`FIR_TAPS - 1) drive_cycle(1'b1, '0);
    flush_pipeline();
    capture_on = 1'b0;
    compare_value("impulse output count", capture_q.size(), `FIR_TAPS);
    for (int k = 0; k < capture_q.size() && k < `FIR_TAPS; k++) begin
      compare_value("fir_d impulse tap",
                    capture_q[k], round_to_sample(acc_t'(fir_coefs[k]) * acc_t'(IMPULSE)));
    end
    end_test("impulse response");
  endtask

  task automatic random_stream();
    sample_t s;
    begin_test();
    for (int i = 0; i < STREAM_CYCLES; i++) begin
      case (i % 16)
        7:       s = -16'sd32768;      // Full-scale negative
        11:      s = 16'sd32767;
        default: s = sample_t'($random(seed));
      endcase
      drive_cycle(1'b1, s);
    end
    flush_pipeline();
    end_test("random stream");
  endtask

  task automatic gap_restart();
    begin_test();
    repeat (FIRST_RUN) drive_cycle(1'b1, sample_t'($random(seed)));
    drive_cycle(1'b0, '0);             // One-cycle gap
    repeat (SECOND_RUN) drive_cycle(1'b1, sample_t'($random(seed)));
    flush_pipeline();
    compare_value("outputs around gap", pulses_seen,
                  (FIRST_RUN - (`FIR_TAPS - 1)) + (SECOND_RUN - (`FIR_TAPS - 1)));
    end_test("gap restart");
  endtask

  task automatic toggled_valid();
    logic v;
    begin_test();
    for (int i = 0; i < TOGGLE_CYCLES; i++) begin
      v = (($random(seed) & 31) != 0);
      drive_cycle(v, sample_t'($random(seed)));
    end
    flush_pipeline();
    end_test("toggled data_valid");
  endtask

  task automatic first_output_latency();
    int   accept_edge;
    int   rise_edge;
    logic seen;
    begin_test();
    seen = 1'b0;
    rise_edge = 0;
    repeat (`FIR_TAPS) drive_cycle(1'b1, sample_t'($random(seed)));
    accept_edge = edge_count + 1;
    for (int i = 0; i < 2 * LATENCY; i++) begin
      drive_cycle(1'b1, sample_t'($random(seed)));
      if (fir_valid && !seen) begin
        seen      = 1'b1;
        rise_edge = edge_count;
      end
    end
    if (!seen) begin
      error_count++;
      $display("error at %0t ns: fir_valid never rose after a full window", $time);
    end else begin
      compare_value("fir_valid latency", rise_edge - accept_edge, LATENCY);
    end
    flush_pipeline();
    end_test("first output latency");
  endtask

  //////////////////////////////////////////////////
  // Output comparator
  always @(posedge clk) begin : compare_outputs
    if (!rst && fir_valid) begin
      pulses_seen++;
      if (!valid_prev) begin
        if (rise_q.size() == 0) begin
          error_count++;
          $display("error at %0t ns: fir_valid rose with no full window expected", $time);
        end else begin
          compare_value("fir_valid rise edge", edge_count, rise_q.pop_front() + LATENCY);
        end
      end
      if (expected_q.size() == 0) begin
        error_count++;
        $display("error at %0t ns: fir_valid high with no output expected", $time);
      end else begin
        compare_value("fir_d", fir_d, expected_q.pop_front());
      end
      if (capture_on) begin
        capture_q.push_back(fir_d);
      end
    end
    valid_prev = fir_valid;
  end

  //////////////////////////////////////////////////
  // Watchdog
  initial begin
    #(TIMEOUT_CYCLES * PERIOD);
    $display("watchdog: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    data_valid = 1'b0;
    data       = '0;
    seed       = 32'h1dc2;
    run_count  = 0;
    for (int k = 0; k < `FIR_TAPS; k++) begin
      model_line[k] = '0;              // Matches the reset taps
    end
    wait (rst === 1'b0);

    idle_after_reset();
    impulse_response();
    random_stream();
    gap_restart();
    toggled_valid();
    first_output_latency();

    if (expected_q.size() != 0 || rise_q.size() != 0) begin
      error_count++;
      $display("error: %0d results still expected at end of run", expected_q.size());
    end
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
